// ==== include/csr_defines.svh ====
`ifndef CSR_DEFINES_SVH
`define CSR_DEFINES_SVH

// enable levels for csr and register writes
`define WRITE_ENABLE  1'b1
`define WRITE_DISABLE 1'b0

// all-zero data word, XLEN wide
// needs csr_pkg compiled first
`define ZERO_WORD {csr_pkg::XLEN{1'b0}}

`endif // CSR_DEFINES_SVH

// ==== source/csr_pkg.sv ====
package csr_pkg;

    // datapath widths
    localparam int XLEN        = 32;
    localparam int REG_ADDR_W  = 5;   // x0..x31
    localparam int CSR_ADDR_W  = 12;
    localparam int COMMIT_ID_W = 3;

    // machine csr addresses
    localparam logic [CSR_ADDR_W-1:0] CSR_MSTATUS  = 12'h300;
    localparam logic [CSR_ADDR_W-1:0] CSR_MIE      = 12'h304;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC    = 12'h305;
    localparam logic [CSR_ADDR_W-1:0] CSR_MSCRATCH = 12'h340;
    localparam logic [CSR_ADDR_W-1:0] CSR_MEPC     = 12'h341;
    localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE   = 12'h342;

    // SYSTEM major opcode
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // funct3, bit 2 marks the immediate forms
    localparam logic [2:0] F3_CSRRW  = 3'b001;
    localparam logic [2:0] F3_CSRRS  = 3'b010;
    localparam logic [2:0] F3_CSRRC  = 3'b011;
    localparam logic [2:0] F3_CSRRWI = 3'b101;
    localparam logic [2:0] F3_CSRRSI = 3'b110;
    localparam logic [2:0] F3_CSRRCI = 3'b111;

    // interrupt bit set + code 11
    localparam logic [XLEN-1:0] CAUSE_M_EXT_INT = 32'h8000_000B;

    // only MPIE (7) and MIE (3) are implemented
    localparam logic [XLEN-1:0] MSTATUS_MASK = 32'h0000_0088;

    // mstatus, raw for csr access, fields for trap entry
    typedef union packed {
        logic [XLEN-1:0] raw;
        struct packed {
            logic [XLEN-9:0] rsv_hi;   // 31:8
            logic            mpie;     // 7
            logic [2:0]      rsv_mid;  // 6:4
            logic            mie;      // 3
            logic [2:0]      rsv_lo;   // 2:0
        } fields;
    } mstatus_u;

endpackage

// ==== source/csr_decode.sv ====
`include "csr_defines.svh"

module csr_decode (
    input  logic                           inst_valid_i,  // already gated by stall
    input  logic [31:0]                    inst_i,
    input  logic [csr_pkg::XLEN-1:0]       rs1_data_i,

    output logic                           req_csr_o,     // valid csr instruction
    output logic                           csrrw_o,
    output logic                           csrrs_o,
    output logic                           csrrc_o,
    output logic [csr_pkg::XLEN-1:0]       csr_op1_o,     // rs1 value or uimm
    output logic [csr_pkg::CSR_ADDR_W-1:0] csr_addr_o,
    output logic [csr_pkg::REG_ADDR_W-1:0] rd_o,
    output logic                           csr_we_o,
    output logic                           reg_we_o
);

    logic [6:0]                     opcode;
    logic [2:0]                     funct3;
    logic [csr_pkg::REG_ADDR_W-1:0] rs1_field;
    logic                           is_system;
    logic                           is_uimm;

    // instruction fields
    assign opcode     = inst_i[6:0];
    assign rd_o       = inst_i[11:7];
    assign funct3     = inst_i[14:12];
    assign rs1_field  = inst_i[19:15];
    assign csr_addr_o = inst_i[31:20];

    assign is_system = inst_valid_i && (opcode == csr_pkg::OPC_SYSTEM);
    assign is_uimm   = funct3[2];   // CSRR*I forms

    // op flags, one hot at most
    always_comb begin
        csrrw_o = 1'b0;
        csrrs_o = 1'b0;
        csrrc_o = 1'b0;
        if (is_system) begin
            case (funct3)
                csr_pkg::F3_CSRRW, csr_pkg::F3_CSRRWI: csrrw_o = 1'b1;
                csr_pkg::F3_CSRRS, csr_pkg::F3_CSRRSI: csrrs_o = 1'b1;
                csr_pkg::F3_CSRRC, csr_pkg::F3_CSRRCI: csrrc_o = 1'b1;
                default: ;  // ecall/ebreak/mret etc, not handled here
            endcase
        end
    end

    assign req_csr_o = csrrw_o | csrrs_o | csrrc_o;

    // uimm is zero extended rs1 field
    assign csr_op1_o = is_uimm ? {{(csr_pkg::XLEN - csr_pkg::REG_ADDR_W){1'b0}}, rs1_field}
                               : rs1_data_i;

    // set/clear with x0 or uimm 0 is a pure read
    assign csr_we_o = (csrrw_o || ((csrrs_o || csrrc_o) && (rs1_field != '0)))
                      ? `WRITE_ENABLE : `WRITE_DISABLE;

    // rd = x0 drops the result
    assign reg_we_o = (req_csr_o && (rd_o != '0)) ? `WRITE_ENABLE : `WRITE_DISABLE;

endmodule

// ==== source/exu_csr_unit.sv ====
`include "csr_defines.svh"

// csr execute: new csr value, old value to rd, stall
module exu_csr_unit (
    // decoded request
    input  logic                            req_csr_i,
    input  logic [csr_pkg::XLEN-1:0]        csr_op1_i,
    input  logic [csr_pkg::CSR_ADDR_W-1:0]  csr_addr_i,
    input  logic                            csr_csrrw_i,
    input  logic                            csr_csrrs_i,
    input  logic                            csr_csrrc_i,
    input  logic [csr_pkg::XLEN-1:0]        csr_rdata_i,   // old csr value
    input  logic [csr_pkg::COMMIT_ID_W-1:0] commit_id_i,

    // write flags from decode
    input  logic                            csr_we_i,
    input  logic                            csr_reg_we_i,
    input  logic [csr_pkg::REG_ADDR_W-1:0]  reg_waddr_i,   // rd

    // writeback side
    input  logic                            wb_busy_i,     // wb stage holds a result
    input  logic                            wb_ready_i,
    output logic                            csr_stall_o,

    input  logic                            int_assert_i,  // squash this cycle

    // to csr file
    output logic [csr_pkg::XLEN-1:0]        csr_wdata_o,
    output logic                            csr_we_o,
    output logic [csr_pkg::CSR_ADDR_W-1:0]  csr_waddr_o,

    // to wb stage
    output logic [csr_pkg::XLEN-1:0]        reg_wdata_o,
    output logic [csr_pkg::REG_ADDR_W-1:0]  reg_waddr_o,
    output logic [csr_pkg::COMMIT_ID_W-1:0] commit_id_o,
    output logic                            csr_reg_we_o
);

    logic valid_op;  // request survives interrupt and stall

    // wb stage full and not draining
    assign csr_stall_o = wb_busy_i & ~wb_ready_i;

    assign valid_op = req_csr_i & ~int_assert_i & ~csr_stall_o;

    // rw: operand, rs: old | op, rc: old & ~op
    assign csr_wdata_o =
        ({csr_pkg::XLEN{csr_csrrw_i}} & csr_op1_i) |
        ({csr_pkg::XLEN{csr_csrrs_i}} & (csr_rdata_i | csr_op1_i)) |
        ({csr_pkg::XLEN{csr_csrrc_i}} & (csr_rdata_i & ~csr_op1_i));

    assign csr_we_o = (valid_op && csr_we_i) ? `WRITE_ENABLE : `WRITE_DISABLE;
    assign csr_waddr_o = csr_addr_i;

    // rd always gets the value before the update
    assign reg_wdata_o  = req_csr_i ? csr_rdata_i : `ZERO_WORD;
    assign reg_waddr_o  = reg_waddr_i;
    assign commit_id_o  = commit_id_i;
    assign csr_reg_we_o = (valid_op && csr_reg_we_i) ? `WRITE_ENABLE : `WRITE_DISABLE;

endmodule

// ==== source/csr_regfile.sv ====
`include "csr_defines.svh"

// machine mode csr storage
// comb read, write and trap update at the clock edge
module csr_regfile (
    input  logic                           clk,
    input  logic                           rst_n_i,

    input  logic [csr_pkg::CSR_ADDR_W-1:0] raddr_i,
    output logic [csr_pkg::XLEN-1:0]       rdata_o,

    input  logic                           we_i,
    input  logic [csr_pkg::CSR_ADDR_W-1:0] waddr_i,
    input  logic [csr_pkg::XLEN-1:0]       wdata_i,

    input  logic                           int_assert_i,  // external interrupt entry
    input  logic [csr_pkg::XLEN-1:0]       pc_i           // pc of squashed instruction
);

    csr_pkg::mstatus_u         mstatus_q;
    logic [csr_pkg::XLEN-1:0]  mie_q;
    logic [csr_pkg::XLEN-1:0]  mtvec_q;
    logic [csr_pkg::XLEN-1:0]  mscratch_q;
    logic [csr_pkg::XLEN-1:0]  mepc_q;
    logic [csr_pkg::XLEN-1:0]  mcause_q;

    // read mux
    always_comb begin
        case (raddr_i)
            csr_pkg::CSR_MSTATUS:  rdata_o = mstatus_q.raw;
            csr_pkg::CSR_MIE:      rdata_o = mie_q;
            csr_pkg::CSR_MTVEC:    rdata_o = mtvec_q;
            csr_pkg::CSR_MSCRATCH: rdata_o = mscratch_q;
            csr_pkg::CSR_MEPC:     rdata_o = mepc_q;
            csr_pkg::CSR_MCAUSE:   rdata_o = mcause_q;
            default:               rdata_o = `ZERO_WORD;  // unimplemented reads zero
        endcase
    end

    // mstatus
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            mstatus_q.raw <= `ZERO_WORD;
        end else if (int_assert_i) begin
            // trap entry, stack the enable
            mstatus_q.fields.mpie <= mstatus_q.fields.mie;
            mstatus_q.fields.mie  <= 1'b0;
        end else if (we_i == `WRITE_ENABLE && waddr_i == csr_pkg::CSR_MSTATUS) begin
            mstatus_q.raw <= wdata_i & csr_pkg::MSTATUS_MASK;  // MIE/MPIE only
        end
    end

    // mepc and mcause, written by trap or csr op
    // mepc low two bits always zero
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            mepc_q   <= `ZERO_WORD;
            mcause_q <= `ZERO_WORD;
        end else if (int_assert_i) begin
            mepc_q   <= {pc_i[csr_pkg::XLEN-1:2], 2'b00};
            mcause_q <= csr_pkg::CAUSE_M_EXT_INT;
        end else if (we_i == `WRITE_ENABLE) begin
            if (waddr_i == csr_pkg::CSR_MEPC) begin
                mepc_q <= {wdata_i[csr_pkg::XLEN-1:2], 2'b00};
            end
            if (waddr_i == csr_pkg::CSR_MCAUSE) begin
                mcause_q <= wdata_i;
            end
        end
    end

    // plain r/w registers, untouched by traps
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            mie_q      <= `ZERO_WORD;
            mtvec_q    <= `ZERO_WORD;  // trap vector base at 0
            mscratch_q <= `ZERO_WORD;
        end else if (!int_assert_i && we_i == `WRITE_ENABLE) begin
            case (waddr_i)
                csr_pkg::CSR_MIE:      mie_q      <= wdata_i;
                csr_pkg::CSR_MTVEC:    mtvec_q    <= wdata_i;  // mode bits kept too
                csr_pkg::CSR_MSCRATCH: mscratch_q <= wdata_i;
                default: ;
            endcase
        end
    end

endmodule

// ==== source/csr_wb_stage.sv ====
`include "csr_defines.svh"

// one entry holding register for the csr result to rd
module csr_wb_stage (
    input  logic                            clk,
    input  logic                            rst_n_i,

    input  logic                            load_i,       // exu reg write enable
    input  logic [csr_pkg::XLEN-1:0]        wdata_i,
    input  logic [csr_pkg::REG_ADDR_W-1:0]  waddr_i,
    input  logic [csr_pkg::COMMIT_ID_W-1:0] commit_id_i,

    input  logic                            wb_ready_i,   // consumer takes result
    output logic                            busy_o,       // entry occupied

    output logic                            reg_we_o,
    output logic [csr_pkg::REG_ADDR_W-1:0]  reg_waddr_o,
    output logic [csr_pkg::XLEN-1:0]        reg_wdata_o,
    output logic [csr_pkg::COMMIT_ID_W-1:0] commit_id_o
);

    logic                            valid_q;
    logic [csr_pkg::XLEN-1:0]        wdata_q;
    logic [csr_pkg::REG_ADDR_W-1:0]  waddr_q;
    logic [csr_pkg::COMMIT_ID_W-1:0] cid_q;

    // valid flag, load wins over drain
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (load_i == `WRITE_ENABLE) begin
            valid_q <= 1'b1;
        end else if (wb_ready_i) begin
            valid_q <= 1'b0;  // taken, nothing new
        end
    end

    // payload, only moves on a load
    always_ff @(posedge clk) begin
        if (load_i == `WRITE_ENABLE) begin
            wdata_q <= wdata_i;
            waddr_q <= waddr_i;
            cid_q   <= commit_id_i;
        end
    end

    assign busy_o      = valid_q;
    assign reg_we_o    = valid_q ? `WRITE_ENABLE : `WRITE_DISABLE;
    assign reg_waddr_o = waddr_q;
    assign reg_wdata_o = wdata_q;
    assign commit_id_o = cid_q;

endmodule

// ==== source/csr_subsys_top.sv ====
module csr_subsys_top (
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  logic                            inst_valid_i,
    input  logic [31:0]                     inst_i,
    input  logic [csr_pkg::XLEN-1:0]        rs1_data_i,
    input  logic [csr_pkg::XLEN-1:0]        pc_i,
    input  logic [csr_pkg::COMMIT_ID_W-1:0] commit_id_i,
    input  logic                            int_assert_i,
    input  logic                            wb_ready_i,
    output logic                            stall_o,
    output logic                            reg_we_o,
    output logic [csr_pkg::REG_ADDR_W-1:0]  reg_waddr_o,
    output logic [csr_pkg::XLEN-1:0]        reg_wdata_o,
    output logic [csr_pkg::COMMIT_ID_W-1:0] commit_id_o
);

    // decode -> exu
    logic                            dec_req, dec_rw, dec_rs, dec_rc;
    logic [csr_pkg::XLEN-1:0]        dec_op1;
    logic [csr_pkg::CSR_ADDR_W-1:0]  dec_addr;
    logic [csr_pkg::REG_ADDR_W-1:0]  dec_rd;
    logic                            dec_csr_we, dec_reg_we;
    // csr file <-> exu
    logic [csr_pkg::XLEN-1:0]        csr_rdata, csr_wdata;
    logic                            csr_we;
    logic [csr_pkg::CSR_ADDR_W-1:0]  csr_waddr;
    // exu -> wb stage
    logic                            ex_reg_we, wb_busy;
    logic [csr_pkg::XLEN-1:0]        ex_reg_wdata;
    logic [csr_pkg::REG_ADDR_W-1:0]  ex_reg_waddr;
    logic [csr_pkg::COMMIT_ID_W-1:0] ex_cid;

    csr_decode u_decode (.inst_valid_i(inst_valid_i), .inst_i(inst_i), .rs1_data_i(rs1_data_i),
        .req_csr_o(dec_req), .csrrw_o(dec_rw), .csrrs_o(dec_rs), .csrrc_o(dec_rc),
        .csr_op1_o(dec_op1), .csr_addr_o(dec_addr), .rd_o(dec_rd),
        .csr_we_o(dec_csr_we), .reg_we_o(dec_reg_we));

    exu_csr_unit u_exu (.req_csr_i(dec_req), .csr_op1_i(dec_op1), .csr_addr_i(dec_addr),
        .csr_csrrw_i(dec_rw), .csr_csrrs_i(dec_rs), .csr_csrrc_i(dec_rc),
        .csr_rdata_i(csr_rdata), .commit_id_i(commit_id_i), .csr_we_i(dec_csr_we),
        .csr_reg_we_i(dec_reg_we), .reg_waddr_i(dec_rd), .wb_busy_i(wb_busy),
        .wb_ready_i(wb_ready_i), .csr_stall_o(stall_o), .int_assert_i(int_assert_i),
        .csr_wdata_o(csr_wdata), .csr_we_o(csr_we), .csr_waddr_o(csr_waddr),
        .reg_wdata_o(ex_reg_wdata), .reg_waddr_o(ex_reg_waddr), .commit_id_o(ex_cid),
        .csr_reg_we_o(ex_reg_we));

    csr_regfile u_regfile (.clk(clk), .rst_n_i(rst_n_i), .raddr_i(dec_addr),
        .rdata_o(csr_rdata), .we_i(csr_we), .waddr_i(csr_waddr), .wdata_i(csr_wdata),
        .int_assert_i(int_assert_i), .pc_i(pc_i));

    csr_wb_stage u_wb (.clk(clk), .rst_n_i(rst_n_i), .load_i(ex_reg_we),
        .wdata_i(ex_reg_wdata), .waddr_i(ex_reg_waddr), .commit_id_i(ex_cid),
        .wb_ready_i(wb_ready_i), .busy_o(wb_busy), .reg_we_o(reg_we_o),
        .reg_waddr_o(reg_waddr_o), .reg_wdata_o(reg_wdata_o), .commit_id_o(commit_id_o));

endmodule

// ==== sim/tb_clkgen.sv ====
module tb_clkgen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;  // period 20
    end

    // reset low for the first 10 rising edges
    initial begin
        rst_n_o = 1'b0;
        repeat (10) @(posedge clk_o);
        #2 rst_n_o = 1'b1;  // released off the edge, like the other inputs
    end

endmodule

// ==== sim/csr_subsys_monitor.sv ====
// watches the writeback port, pops expected results in order
module csr_subsys_monitor (
    input logic                            clk_i,
    input logic                            rst_n_i,
    input logic                            wb_ready_i,
    input logic                            reg_we_i,
    input logic [csr_pkg::REG_ADDR_W-1:0]  reg_waddr_i,
    input logic [csr_pkg::XLEN-1:0]        reg_wdata_i,
    input logic [csr_pkg::COMMIT_ID_W-1:0] commit_id_i
);

    // expected results, one entry per accepted instruction with rd != x0
    logic [csr_pkg::REG_ADDR_W-1:0]  exp_rd_q  [$];
    logic [csr_pkg::XLEN-1:0]        exp_val_q [$];
    logic [csr_pkg::COMMIT_ID_W-1:0] exp_cid_q [$];

    int value_errs = 0;
    int proto_errs = 0;

    task automatic push_expected(input logic [csr_pkg::REG_ADDR_W-1:0] rd,
                                 input logic [csr_pkg::XLEN-1:0] val,
                                 input logic [csr_pkg::COMMIT_ID_W-1:0] cid);
        exp_rd_q.push_back(rd);
        exp_val_q.push_back(val);
        exp_cid_q.push_back(cid);
    endtask

    function automatic int pending();
        return exp_rd_q.size();
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR %s: got %h expected %h at %0t", name, got, exp, $time);
            value_errs++;
        end
    endtask

    // negedge: we and ready settled, take happens at the coming posedge
    always @(negedge clk_i) begin
        if (rst_n_i && reg_we_i && wb_ready_i) begin
            if (exp_rd_q.size() == 0) begin
                $display("writeback to register %0d at %0t with no result outstanding",
                         reg_waddr_i, $time);
                proto_errs++;
            end else begin
                compare_value("reg_waddr_o", 32'(reg_waddr_i), 32'(exp_rd_q.pop_front()));
                compare_value("reg_wdata_o", reg_wdata_i, exp_val_q.pop_front());
                compare_value("commit_id_o", 32'(commit_id_i), 32'(exp_cid_q.pop_front()));
            end
        end
    end

endmodule

// ==== sim/csr_subsys_checker.sv ====
// protocol assertions on the writeback side of the top level
module csr_subsys_checker (
    input logic                            clk_i,
    input logic                            rst_n_i,
    input logic                            stall_i,
    input logic                            int_i,
    input logic                            wb_ready_i,
    input logic                            reg_we_i,
    input logic [csr_pkg::REG_ADDR_W-1:0]  reg_waddr_i,
    input logic [csr_pkg::XLEN-1:0]        reg_wdata_i,
    input logic [csr_pkg::COMMIT_ID_W-1:0] commit_id_i
);

    int assert_fails = 0;  // summed into the closing line

    // held result does not move while the consumer stalls
    a_hold_on_stall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        stall_i |=> $stable(reg_we_i) && $stable(reg_waddr_i)
                    && $stable(reg_wdata_i) && $stable(commit_id_i))
        else begin
            $error("writeback outputs changed while stalled");
            assert_fails++;
        end

    // squashed instruction loads nothing, stage empty once old result is gone
    a_irq_no_result: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        int_i && (!reg_we_i || wb_ready_i) |=> !reg_we_i)
        else begin
            $error("interrupted instruction produced a writeback");
            assert_fails++;
        end

    a_we_clear_after_reset: assert property (@(posedge clk_i) !rst_n_i |=> !reg_we_i)
        else begin
            $error("writeback enable high right after reset");
            assert_fails++;
        end

endmodule

bind csr_subsys_top csr_subsys_checker u_checker (
    .clk_i(clk), .rst_n_i(rst_n_i), .stall_i(stall_o), .int_i(int_assert_i),
    .wb_ready_i(wb_ready_i), .reg_we_i(reg_we_o),
    .reg_waddr_i(reg_waddr_o), .reg_wdata_i(reg_wdata_o), .commit_id_i(commit_id_o)
);

// ==== sim/csr_subsys_tb.sv ====
module csr_subsys_tb;

    localparam int          CLK_PERIOD = 20;
    localparam int          TAB_MAX    = 64;
    localparam logic [31:0] NOP_INST   = 32'h0000_0013;  // addi x0, x0, 0

    logic                            clk, rst_n, inst_valid, irq, wb_ready;
    logic [31:0]                     inst;
    logic [csr_pkg::XLEN-1:0]        rs1_data, pc, reg_wdata;
    logic [csr_pkg::COMMIT_ID_W-1:0] commit_id, wb_commit_id;
    logic                            stall, reg_we;
    logic [csr_pkg::REG_ADDR_W-1:0]  reg_waddr;

    // stimulus table and expected writeback
    logic [31:0] tab_inst [TAB_MAX];
    logic [31:0] tab_rs1 [TAB_MAX];
    logic        tab_irq [TAB_MAX];
    logic        tab_rdy [TAB_MAX];
    logic        tab_csr [TAB_MAX];  // csr instruction, held while stalled
    logic        tab_exp_we [TAB_MAX];
    logic [4:0]  tab_exp_rd [TAB_MAX];
    logic [31:0] tab_exp_val [TAB_MAX];
    int          n_entries = 0;
    logic        table_built = 1'b0;
    integer      seed;

    // reference csr state, follows the table in acceptance order
    logic [31:0] m_mstatus, m_mie, m_mtvec, m_mscratch, m_mepc, m_mcause;

    logic held;
    int   drain;
    int   left_errs;
    int   total;

    tb_clkgen u_clkgen (.clk_o(clk), .rst_n_o(rst_n));

    csr_subsys_top DUT (.clk(clk), .rst_n_i(rst_n), .inst_valid_i(inst_valid), .inst_i(inst),
        .rs1_data_i(rs1_data), .pc_i(pc), .commit_id_i(commit_id), .int_assert_i(irq),
        .wb_ready_i(wb_ready), .stall_o(stall), .reg_we_o(reg_we), .reg_waddr_o(reg_waddr),
        .reg_wdata_o(reg_wdata), .commit_id_o(wb_commit_id));

    csr_subsys_monitor mon (.clk_i(clk), .rst_n_i(rst_n), .wb_ready_i(wb_ready),
        .reg_we_i(reg_we), .reg_waddr_i(reg_waddr), .reg_wdata_i(reg_wdata),
        .commit_id_i(wb_commit_id));

    function automatic logic [31:0] model_read(input logic [11:0] addr);
        case (addr)
            csr_pkg::CSR_MSTATUS:  return m_mstatus;
            csr_pkg::CSR_MIE:      return m_mie;
            csr_pkg::CSR_MTVEC:    return m_mtvec;
            csr_pkg::CSR_MSCRATCH: return m_mscratch;
            csr_pkg::CSR_MEPC:     return m_mepc;
            csr_pkg::CSR_MCAUSE:   return m_mcause;
            default:               return 32'h0;  // unknown csr
        endcase
    endfunction

    task automatic model_write(input logic [11:0] addr, input logic [31:0] val);
        case (addr)
            csr_pkg::CSR_MSTATUS:  m_mstatus  = val & 32'h0000_0088;  // MPIE, MIE
            csr_pkg::CSR_MIE:      m_mie      = val;
            csr_pkg::CSR_MTVEC:    m_mtvec    = val;
            csr_pkg::CSR_MSCRATCH: m_mscratch = val;
            csr_pkg::CSR_MEPC:     m_mepc     = val & ~32'h3;
            csr_pkg::CSR_MCAUSE:   m_mcause   = val;
            default: ;  // write ignored
        endcase
    endtask

    // one csr entry: read old, then write, set or clear
    task automatic add_csr(input logic [2:0] f3, input logic [11:0] addr, input logic [4:0] rs1f,
                           input logic [4:0] rd, input logic [31:0] rs1_val,
                           input logic int_flag, input logic rdy);
        logic [31:0] op;
        logic [31:0] old;
        op  = f3[2] ? {27'b0, rs1f} : rs1_val;  // uimm forms
        old = model_read(addr);
        tab_inst[n_entries] = {addr, rs1f, f3, rd, csr_pkg::OPC_SYSTEM};
        tab_rs1[n_entries]  = rs1_val;
        tab_irq[n_entries]  = int_flag;
        tab_rdy[n_entries]  = rdy;
        tab_csr[n_entries]  = 1'b1;
        tab_exp_rd[n_entries]  = rd;
        tab_exp_val[n_entries] = old;
        if (int_flag) begin
            // trap entry, instruction dropped
            m_mepc    = (32'h0000_1000 + 32'(n_entries) * 4) & ~32'h3;
            m_mcause  = 32'h8000_000B;
            m_mstatus = m_mstatus[3] ? 32'h0000_0080 : 32'h0;
            tab_exp_we[n_entries] = 1'b0;
        end else begin
            if (f3[1:0] == 2'b01) model_write(addr, op);
            else if (rs1f != 5'd0 && f3[1:0] == 2'b10) model_write(addr, old | op);
            else if (rs1f != 5'd0 && f3[1:0] == 2'b11) model_write(addr, old & ~op);
            tab_exp_we[n_entries] = (rd != 5'd0);
        end
        n_entries++;
    endtask

    task automatic add_idle(input logic rdy);
        tab_inst[n_entries] = NOP_INST;
        tab_rs1[n_entries]  = 32'h0;
        tab_irq[n_entries]  = 1'b0;
        tab_rdy[n_entries]  = rdy;
        tab_csr[n_entries]  = 1'b0;
        tab_exp_we[n_entries] = 1'b0;
        n_entries++;
    endtask

    task automatic build_table();
        seed = 32'h263e3e66;
        {m_mstatus, m_mie, m_mtvec, m_mscratch, m_mepc, m_mcause} = '0;
        // write then two plain reads of mscratch
        add_csr(csr_pkg::F3_CSRRW, csr_pkg::CSR_MSCRATCH, 5'd5, 5'd1, $random(seed), 0, 1);
        add_csr(csr_pkg::F3_CSRRS, csr_pkg::CSR_MSCRATCH, 5'd0, 5'd2, $random(seed), 0, 1);
        add_csr(csr_pkg::F3_CSRRS, csr_pkg::CSR_MSCRATCH, 5'd0, 5'd3, $random(seed), 0, 1);
        // set/clear, register and immediate
        add_csr(csr_pkg::F3_CSRRS, csr_pkg::CSR_MSCRATCH, 5'd6, 5'd4, $random(seed), 0, 1);
        add_csr(csr_pkg::F3_CSRRC, csr_pkg::CSR_MSCRATCH, 5'd7, 5'd5, $random(seed), 0, 1);
        add_csr(csr_pkg::F3_CSRRSI, csr_pkg::CSR_MTVEC, 5'h15, 5'd6, $random(seed), 0, 1);
        add_csr(csr_pkg::F3_CSRRCI, csr_pkg::CSR_MTVEC, 5'h04, 5'd7, $random(seed), 0, 1);
        add_csr(csr_pkg::F3_CSRRWI, csr_pkg::CSR_MTVEC, 5'h1f, 5'd8, $random(seed), 0, 1);
        add_csr(csr_pkg::F3_CSRRC, csr_pkg::CSR_MTVEC, 5'd0, 5'd9, $random(seed), 0, 1);
        add_csr(csr_pkg::F3_CSRRS, csr_pkg::CSR_MSCRATCH, 5'd0, 5'd10, $random(seed), 0, 1);
        // masking, alignment, unknown csr, rd = x0
        add_csr(csr_pkg::F3_CSRRW, csr_pkg::CSR_MSTATUS, 5'd8, 5'd11, 32'hffff_ffff, 0, 1);
        add_csr(csr_pkg::F3_CSRRS, csr_pkg::CSR_MSTATUS, 5'd0, 5'd12, $random(seed), 0, 1);
        add_csr(csr_pkg::F3_CSRRW, csr_pkg::CSR_MEPC, 5'd9, 5'd13, 32'h1234_5677, 0, 1);
        add_csr(csr_pkg::F3_CSRRS, csr_pkg::CSR_MEPC, 5'd0, 5'd14, $random(seed), 0, 1);
        add_csr(csr_pkg::F3_CSRRW, 12'h7c0, 5'd10, 5'd15, $random(seed), 0, 1);
        add_csr(csr_pkg::F3_CSRRS, 12'h7c0, 5'd0, 5'd16, $random(seed), 0, 1);
        add_csr(csr_pkg::F3_CSRRW, csr_pkg::CSR_MSCRATCH, 5'd11, 5'd0, $random(seed), 0, 1);
        add_csr(csr_pkg::F3_CSRRS, csr_pkg::CSR_MSCRATCH, 5'd0, 5'd17, $random(seed), 0, 1);
        // MIE on, then interrupt on a mscratch write
        add_csr(csr_pkg::F3_CSRRWI, csr_pkg::CSR_MSTATUS, 5'h08, 5'd18, $random(seed), 0, 1);
        add_csr(csr_pkg::F3_CSRRW, csr_pkg::CSR_MSCRATCH, 5'd12, 5'd19, $random(seed), 1, 1);
        add_csr(csr_pkg::F3_CSRRS, csr_pkg::CSR_MEPC, 5'd0, 5'd20, $random(seed), 0, 1);
        add_csr(csr_pkg::F3_CSRRS, csr_pkg::CSR_MCAUSE, 5'd0, 5'd21, $random(seed), 0, 1);
        add_csr(csr_pkg::F3_CSRRS, csr_pkg::CSR_MSTATUS, 5'd0, 5'd22, $random(seed), 0, 1);
        add_csr(csr_pkg::F3_CSRRS, csr_pkg::CSR_MSCRATCH, 5'd0, 5'd23, $random(seed), 0, 1);
        // back to back with the consumer not ready
        add_csr(csr_pkg::F3_CSRRW, csr_pkg::CSR_MIE, 5'd13, 5'd24, $random(seed), 0, 0);
        add_csr(csr_pkg::F3_CSRRS, csr_pkg::CSR_MIE, 5'd0, 5'd25, $random(seed), 0, 0);
        add_idle(1'b0);
        add_idle(1'b0);
        add_idle(1'b0);
        add_csr(csr_pkg::F3_CSRRCI, csr_pkg::CSR_MIE, 5'h0b, 5'd26, $random(seed), 0, 0);
        add_csr(csr_pkg::F3_CSRRS, csr_pkg::CSR_MIE, 5'd0, 5'd27, $random(seed), 0, 1);
        add_idle(1'b0);
        add_idle(1'b0);
        add_idle(1'b1);
    endtask

    // on a repeat after a stall the consumer is made ready
    task automatic drive_entry(input int idx, input logic release_rdy);
        inst_valid = 1'b1;
        inst       = tab_inst[idx];
        rs1_data   = tab_rs1[idx];
        pc         = 32'h0000_1000 + 32'(idx) * 4;
        commit_id  = idx[2:0];
        irq        = tab_irq[idx];
        wb_ready   = release_rdy ? 1'b1 : tab_rdy[idx];
    endtask

    // watchdog, scaled to the table length
    initial begin
        wait (table_built);
        #((n_entries * 4 + 50) * CLK_PERIOD);
        $display("timeout: run did not finish within %0d cycles", n_entries * 4 + 50);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        inst_valid = 1'b0;
        inst       = NOP_INST;
        rs1_data   = '0;
        pc         = '0;
        commit_id  = '0;
        irq        = 1'b0;
        wb_ready   = 1'b1;
        left_errs  = 0;
        build_table();
        table_built = 1'b1;
        wait (rst_n);
        for (int i = 0; i < n_entries; i++) begin
            held = 1'b0;
            do begin
                @(posedge clk);
                #2;
                drive_entry(i, held);
                #1;
                held = stall && tab_csr[i] && !tab_irq[i];  // squashed entries move on
            end while (held);
            if (tab_exp_we[i]) begin
                mon.push_expected(tab_exp_rd[i], tab_exp_val[i], i[2:0]);
            end
        end
        @(posedge clk);
        #2;
        inst_valid = 1'b0;
        inst       = NOP_INST;
        irq        = 1'b0;
        wb_ready   = 1'b1;
        drain = 0;
        while ((mon.pending() != 0 || reg_we) && drain < 10) begin
            @(posedge clk);
            #1;
            drain++;
        end
        if (mon.pending() != 0) begin
            $display("%0d expected results never came out of the writeback port",
                     mon.pending());
            left_errs = mon.pending();
        end
        total = mon.value_errs + mon.proto_errs + left_errs + DUT.u_checker.assert_fails;
        $display("errors: value %0d, protocol %0d, missing %0d, assertion %0d",
                 mon.value_errs, mon.proto_errs, left_errs, DUT.u_checker.assert_fails);
        if (total == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== csr_subsys.f ====
+incdir+include
source/csr_pkg.sv
source/csr_decode.sv
source/exu_csr_unit.sv
source/csr_regfile.sv
source/csr_wb_stage.sv
source/csr_subsys_top.sv
sim/tb_clkgen.sv
sim/csr_subsys_monitor.sv
sim/csr_subsys_checker.sv
sim/csr_subsys_tb.sv
